/* compile.f */
+incdir+src
src/io_map_pkg.sv
src/periph_pkg.sv
src/io_decoder.sv
src/bus_ctrl_fsm.sv
src/os_timer.sv
src/spi_byte_master.sv
src/io_regs.sv
src/io_unit_top.sv
testbench/io_unit_sva.sv
testbench/io_unit_tb.sv

/* Bender.yml */
package:
  name: io_unit

export_include_dirs:
  - src

sources:
  - src/io_map_pkg.sv
  - src/periph_pkg.sv
  - src/io_decoder.sv
  - src/bus_ctrl_fsm.sv
  - src/os_timer.sv
  - src/spi_byte_master.sv
  - src/io_regs.sv
  - src/io_unit_top.sv
  - target: simulation
    files:
      - testbench/io_unit_sva.sv
      - testbench/io_unit_tb.sv

/* testbench/io_unit_tb.sv */
`timescale 1ns/1ps
`include "io_unit_params.svh"

module io_unit_tb;

    localparam int HALF_BIT = `IO_SPI_HALF_BIT;
    // Whole run is a few hundred cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int T1_COUNT = 20;
    localparam int T2_COUNT = 40;
    localparam logic [`IO_ADDR_W-1:0] A_UNMAPPED = 27'hC02700;

    logic                  clk;
    logic                  reset;
    logic [`IO_ADDR_W-1:0] bus_addr;
    logic [`IO_DATA_W-1:0] bus_data;
    logic                  bus_we;
    logic                  bus_start;
    logic                  spi_nint;
    logic [3:0]            gpi;
    logic                  boot_mode;
    logic [`IO_DATA_W-1:0] bus_q;
    logic                  bus_done;
    logic                  spi_sclk;
    logic                  spi_mosi;
    logic                  spi_cs;
    logic [3:0]            gpo;
    logic                  ost1_int;
    logic                  ost2_int;

    logic [15:0] lfsr = 16'd51201;
    int          cycle = 0;
    int          t1_pulses = 0;
    int          t2_pulses = 0;
    int          t1_last = 0;
    int          done_cycle = 0;
    int          latency = 0;

    // SPI slave is a plain loopback
    io_unit_top UUT (
        .clk         (clk),
        .reset       (reset),
        .i_bus_addr  (bus_addr),
        .i_bus_data  (bus_data),
        .i_bus_we    (bus_we),
        .i_bus_start (bus_start),
        .i_spi_miso  (spi_mosi),
        .i_spi_nint  (spi_nint),
        .i_gpi       (gpi),
        .i_boot_mode (boot_mode),
        .o_bus_q     (bus_q),
        .o_bus_done  (bus_done),
        .o_spi_sclk  (spi_sclk),
        .o_spi_mosi  (spi_mosi),
        .o_spi_cs    (spi_cs),
        .o_gpo       (gpo),
        .o_ost1_int  (ost1_int),
        .o_ost2_int  (ost2_int)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Cycle count, timeout, IRQ monitors
    // ----------------------------------------
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle);
            $display("FAIL: see errors above");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // Mid-cycle, away from the edges
    always @(negedge clk)
    begin
        if (ost1_int)
        begin
            t1_pulses++;
            t1_last = cycle;
        end
        if (ost2_int)
            t2_pulses++;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Called 1 ns after an edge; returns 1 ns after an edge with one idle cycle
    task automatic bus_access(input logic [`IO_ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic we, output logic [31:0] q);
        int edges;
        edges     = 0;
        bus_addr  = addr;
        bus_data  = data;
        bus_we    = we;
        bus_start = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
            edges++;
        end
        while (!bus_done);
        // First edge only samples start
        latency    = edges - 1;
        done_cycle = cycle;
        q          = bus_q;
        @(posedge clk);
        #1;
        bus_start = 1'b0;
        bus_we    = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_defaults();
        logic [31:0] q;
        check_value(spi_cs, 1'b1, "chip select after reset");
        check_value(gpo, 4'd0, "GPO after reset");
        check_value(bus_done, 1'b0, "bus done after reset");
        check_value(bus_q, 32'd0, "read data after reset");
        check_value({ost2_int, ost1_int}, 2'b00, "timer interrupts after reset");
        check_value(spi_sclk, 1'b0, "SCLK after reset");
        bus_access(`IO_A_GPIO, 32'd0, 1'b0, q);
        check_value(q, {24'd0, 4'd0, gpi}, "GPIO read after reset");
        check_value(latency, 2, "GPIO read latency");
    endtask

    task automatic gpio_and_cs_writes();
        logic [31:0] q;
        logic [3:0]  gpo_val;
        logic [3:0]  gpo_inv;
        gpo_val = next_bits(4);
        gpo_inv = ~gpo_val;
        bus_access(`IO_A_GPIO, {24'hFFFFFF, gpo_val, 4'h5}, 1'b1, q);
        check_value(latency, 2, "GPIO write latency");
        check_value(gpo, gpo_val, "GPO after write");
        // Every GPO bit toggles on the second write
        bus_access(`IO_A_GPIO, {24'h000000, gpo_inv, 4'hA}, 1'b1, q);
        check_value(gpo, gpo_inv, "GPO after inverted write");
        bus_access(`IO_A_GPIO, 32'd0, 1'b0, q);
        check_value(q, {24'd0, gpo_inv, gpi}, "GPIO readback");
        bus_access(`IO_A_SPI_CS, 32'hFFFF_FFFE, 1'b1, q);
        check_value(spi_cs, 1'b0, "chip select after write of 0");
        bus_access(`IO_A_SPI_CS, 32'd0, 1'b0, q);
        check_value(q, 32'd0, "chip select readback low");
        bus_access(`IO_A_SPI_CS, 32'd1, 1'b1, q);
        check_value(spi_cs, 1'b1, "chip select after write of 1");
        bus_access(`IO_A_SPI_CS, 32'd0, 1'b0, q);
        check_value(q, 32'd1, "chip select readback high");
    endtask

    task automatic spi_loopback();
        logic [31:0] q;
        logic [7:0]  tx;
        tx        = next_bits(8);
        spi_nint  = next_bits(1);
        boot_mode = next_bits(1);
        bus_access(`IO_A_SPI_DATA, {24'hA5A5A5, tx}, 1'b1, q);
        check_value(latency >= 16 * HALF_BIT, 1'b1, "SPI write waits for the full byte");
        check_value(spi_sclk, 1'b0, "SCLK idle after byte");
        bus_access(`IO_A_SPI_DATA, 32'd0, 1'b0, q);
        check_value(q, {24'd0, tx}, "SPI loopback byte");
        bus_access(`IO_A_SPI_NINT, 32'd0, 1'b0, q);
        check_value(q, {31'd0, spi_nint}, "SPI nint read");
        bus_access(`IO_A_BOOT, 32'd0, 1'b0, q);
        check_value(q, {31'd0, boot_mode}, "boot mode read");
    endtask

    task automatic timer_expiry();
        logic [31:0] q;
        int          base1;
        int          base2;
        int          start;
        base1 = t1_pulses;
        base2 = t2_pulses;
        bus_access(`IO_A_T1_VAL, T1_COUNT, 1'b1, q);
        bus_access(`IO_A_T1_CTRL, 32'd1, 1'b1, q);
        start = done_cycle;
        // Run past the end of the N..N+4 window
        repeat (T1_COUNT + 6) @(posedge clk);
        #1;
        check_value(t1_pulses - base1, 1, "timer 1 interrupt pulses");
        check_value((t1_last - start >= T1_COUNT) && (t1_last - start <= T1_COUNT + 4),
                    1'b1, "timer 1 interrupt inside its window");
        check_value(t2_pulses - base2, 0, "timer 2 pulses while idle");
        bus_access(`IO_A_T1_VAL, 32'd0, 1'b0, q);
        check_value(q, 32'd0, "timer value read");
    endtask

    task automatic timer_stop();
        logic [31:0] q;
        int          base2;
        base2 = t2_pulses;
        bus_access(`IO_A_T2_VAL, T2_COUNT, 1'b1, q);
        bus_access(`IO_A_T2_CTRL, 32'd1, 1'b1, q);
        bus_access(`IO_A_T2_CTRL, 32'd0, 1'b1, q);
        repeat (2 * T2_COUNT) @(posedge clk);
        #1;
        check_value(t2_pulses - base2, 0, "timer 2 pulses after stop");
    endtask

    task automatic unmapped_access();
        logic [31:0] q;
        logic [3:0]  gpo_before;
        logic        cs_before;
        gpo_before = gpo;
        cs_before  = spi_cs;
        // Data that would flip GPO and chip select if the write landed
        bus_access(A_UNMAPPED, {24'hFFFFFF, ~gpo_before, 3'b111, ~cs_before}, 1'b1, q);
        check_value(latency, 2, "unmapped write latency");
        bus_access(A_UNMAPPED, 32'd0, 1'b0, q);
        check_value(latency, 2, "unmapped read latency");
        check_value(q, 32'd0, "unmapped read data");
        check_value(gpo, gpo_before, "GPO after unmapped write");
        check_value(spi_cs, cs_before, "chip select after unmapped write");
        bus_access(`IO_A_GPIO, 32'd0, 1'b0, q);
        check_value(q, {24'd0, gpo_before, gpi}, "GPIO readback after unmapped write");
    endtask

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        bus_addr  = '0;
        bus_data  = '0;
        bus_we    = 1'b0;
        bus_start = 1'b0;
        spi_nint  = 1'b1;
        gpi       = next_bits(4);
        boot_mode = next_bits(1);
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_defaults();
        gpio_and_cs_writes();
        spi_loopback();
        timer_expiry();
        timer_stop();
        unmapped_access();

        check_value(UUT.u_sva.fail_count, 0, "assertion failures");
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* testbench/io_unit_sva.sv */
`timescale 1ns/1ps

module io_unit_sva
(
    input logic clk,
    input logic reset,
    input logic i_bus_start,
    input logic i_bus_done,
    input logic i_spi_cs
);

    int fail_count = 0;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        i_bus_done |=> !i_bus_done)
    else
    begin
        fail_count++;
        $error("Bus done held high for more than one cycle");
    end

    // Master holds start until it sees done
    done_needs_start: assert property (@(posedge clk) disable iff (reset)
        $rose(i_bus_done) |-> i_bus_start)
    else
    begin
        fail_count++;
        $error("Bus done rose without a pending start");
    end

    cs_high_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> i_spi_cs)
    else
    begin
        fail_count++;
        $error("Chip select not high on leaving reset");
    end

endmodule

bind io_unit_top io_unit_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .i_bus_start (i_bus_start),
    .i_bus_done  (o_bus_done),
    .i_spi_cs    (o_spi_cs)
);

/* src/io_unit_top.sv */
`timescale 1ns/1ps
`include "io_unit_params.svh"

module io_unit_top
    import io_map_pkg::*, periph_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`IO_ADDR_W-1:0] i_bus_addr,
    input  logic [`IO_DATA_W-1:0] i_bus_data,
    input  logic                 i_bus_we,
    input  logic                 i_bus_start,
    input  logic                 i_spi_miso,
    input  logic                 i_spi_nint,
    input  gpi_t                 i_gpi,
    input  logic                 i_boot_mode,
    output logic [`IO_DATA_W-1:0] o_bus_q,
    output logic                 o_bus_done,
    output logic                 o_spi_sclk,
    output logic                 o_spi_mosi,
    output logic                 o_spi_cs,
    output gpo_t                 o_gpo,
    output logic                 o_ost1_int,
    output logic                 o_ost2_int
);

    io_sel_t  sel;
    io_byte_t spi_rx;
    logic     spi_start;
    logic     spi_done;
    logic     reg_we;
    logic     capture;
    logic     t1_set;
    logic     t1_trigger;
    logic     t1_stop;
    logic     t2_set;
    logic     t2_trigger;
    logic     t2_stop;

    // ----------------------------------------
    // Decode and control
    // ----------------------------------------
    io_decoder u_decoder (
        .i_bus_addr (i_bus_addr),
        .o_sel      (sel)
    );

    bus_ctrl_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .i_bus_start  (i_bus_start),
        .i_bus_we     (i_bus_we),
        .i_bus_data0  (i_bus_data[0]),
        .i_sel        (sel),
        .i_spi_done   (spi_done),
        .o_bus_done   (o_bus_done),
        .o_spi_start  (spi_start),
        .o_reg_we     (reg_we),
        .o_capture    (capture),
        .o_t1_set     (t1_set),
        .o_t1_trigger (t1_trigger),
        .o_t1_stop    (t1_stop),
        .o_t2_set     (t2_set),
        .o_t2_trigger (t2_trigger),
        .o_t2_stop    (t2_stop)
    );

    // ----------------------------------------
    // Peripherals
    // ----------------------------------------

    // CH376T port
    spi_byte_master #(
        .HALF_BIT_CLKS (`IO_SPI_HALF_BIT)
    ) u_spi (
        .clk     (clk),
        .reset   (reset),
        .i_start (spi_start),
        .i_tx    (i_bus_data[7:0]),
        .i_miso  (i_spi_miso),
        .o_done  (spi_done),
        .o_rx    (spi_rx),
        .o_sclk  (o_spi_sclk),
        .o_mosi  (o_spi_mosi)
    );

    os_timer u_ost1 (
        .clk       (clk),
        .reset     (reset),
        .i_value   (i_bus_data),
        .i_set     (t1_set),
        .i_trigger (t1_trigger),
        .i_stop    (t1_stop),
        .o_int     (o_ost1_int)
    );

    os_timer u_ost2 (
        .clk       (clk),
        .reset     (reset),
        .i_value   (i_bus_data),
        .i_set     (t2_set),
        .i_trigger (t2_trigger),
        .i_stop    (t2_stop),
        .o_int     (o_ost2_int)
    );

    io_regs #(
        .DATA_W (`IO_DATA_W)
    ) u_regs (
        .clk         (clk),
        .reset       (reset),
        .i_sel       (sel),
        .i_reg_we    (reg_we),
        .i_capture   (capture),
        .i_bus_data  (i_bus_data),
        .i_spi_rx    (spi_rx),
        .i_spi_nint  (i_spi_nint),
        .i_gpi       (i_gpi),
        .i_boot_mode (i_boot_mode),
        .o_gpo       (o_gpo),
        .o_spi_cs    (o_spi_cs),
        .o_bus_q     (o_bus_q)
    );

endmodule

/* src/io_regs.sv */
`timescale 1ns/1ps

module io_regs
    import io_map_pkg::*, periph_pkg::*;
#(
    parameter int DATA_W = 32
)
(
    input  logic              clk,
    input  logic              reset,
    input  io_sel_t           i_sel,
    input  logic              i_reg_we,
    input  logic              i_capture,
    input  logic [DATA_W-1:0] i_bus_data,
    input  io_byte_t          i_spi_rx,
    input  logic              i_spi_nint,
    input  gpi_t              i_gpi,
    input  logic              i_boot_mode,
    output gpo_t              o_gpo,
    output logic              o_spi_cs,
    output logic [DATA_W-1:0] o_bus_q
);

    logic [DATA_W-1:0] rd_data;

    // ----------------------------------------
    // Readback mux
    // ----------------------------------------
    always_comb
    begin
        case (i_sel)
            SEL_SPI_DATA: rd_data = DATA_W'(i_spi_rx);
            SEL_SPI_CS:   rd_data = DATA_W'(o_spi_cs);
            SEL_SPI_NINT: rd_data = DATA_W'(i_spi_nint);
            SEL_GPIO:     rd_data = DATA_W'({o_gpo, i_gpi});
            SEL_BOOT:     rd_data = DATA_W'(i_boot_mode);
            // Timers are write only
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_gpo    <= '0;
            o_spi_cs <= 1'b1;
            o_bus_q  <= '0;
        end
        else
        begin
            if (i_reg_we && (i_sel == SEL_GPIO))
                o_gpo <= i_bus_data[7:4];
            if (i_reg_we && (i_sel == SEL_SPI_CS))
                o_spi_cs <= i_bus_data[0];
            // Held until the next access completes
            if (i_capture)
                o_bus_q <= rd_data;
        end
    end

endmodule

/* src/spi_byte_master.sv */
`timescale 1ns/1ps
`include "io_unit_params.svh"

module spi_byte_master
    import periph_pkg::*;
#(
    parameter int HALF_BIT_CLKS = `IO_SPI_HALF_BIT
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     i_start,
    input  io_byte_t i_tx,
    input  logic     i_miso,
    output logic     o_done,
    output io_byte_t o_rx,
    output logic     o_sclk,
    output logic     o_mosi
);

    localparam int CNT_W = (HALF_BIT_CLKS > 1) ? $clog2(HALF_BIT_CLKS) : 1;
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(HALF_BIT_CLKS - 1);

    logic             busy;
    logic [CNT_W-1:0] half_cnt;
    logic [3:0]       edge_cnt;
    io_byte_t         tx_sr;
    io_byte_t         rx_sr;
    logic             half_tick;

    assign half_tick = busy && (half_cnt == HALF_LAST);
    // MSB first, already on the wire before the first rising edge
    assign o_mosi    = tx_sr[7];

    // ----------------------------------------
    // Divider, edge counter, TX shifter
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
            tx_sr    <= '0;
            o_sclk   <= 1'b0;
            o_done   <= 1'b0;
            o_rx     <= '0;
        end
        else
        begin
            o_done <= 1'b0;
            if (!busy)
            begin
                if (i_start)
                begin
                    busy     <= 1'b1;
                    half_cnt <= '0;
                    edge_cnt <= '0;
                    tx_sr    <= i_tx;
                end
            end
            else if (half_tick)
            begin
                half_cnt <= '0;
                o_sclk   <= ~o_sclk;
                edge_cnt <= edge_cnt + 4'd1;
                // Falling edge moves the next bit out
                if (o_sclk)
                    tx_sr <= {tx_sr[6:0], 1'b0};
                // 16th edge ends the byte with SCLK back low
                if (edge_cnt == 4'd15)
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                    o_rx   <= rx_sr;
                end
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // Sample MISO as SCLK rises
    always_ff @(posedge clk)
    begin
        if (half_tick && !o_sclk)
            rx_sr <= {rx_sr[6:0], i_miso};
    end

endmodule

/* src/os_timer.sv */
`timescale 1ns/1ps

module os_timer
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  timer_val_t i_value,
    input  logic       i_set,
    input  logic       i_trigger,
    input  logic       i_stop,
    output logic       o_int
);

    timer_val_t reload;
    timer_val_t count;
    logic       running;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload  <= '0;
            count   <= '0;
            running <= 1'b0;
            o_int   <= 1'b0;
        end
        else
        begin
            o_int <= 1'b0;
            if (i_set)
                reload <= i_value;

            if (i_stop)
            begin
                running <= 1'b0;
            end
            else if (i_trigger)
            begin
                count   <= reload;
                running <= 1'b1;
            end
            else if (running)
            begin
                // Fire once at zero, then sit idle until the next trigger
                if (count == '0)
                begin
                    running <= 1'b0;
                    o_int   <= 1'b1;
                end
                else
                begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

/* src/bus_ctrl_fsm.sv */
`timescale 1ns/1ps

module bus_ctrl_fsm
    import io_map_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    i_bus_start,
    input  logic    i_bus_we,
    input  logic    i_bus_data0,
    input  io_sel_t i_sel,
    input  logic    i_spi_done,
    output logic    o_bus_done,
    output logic    o_spi_start,
    output logic    o_reg_we,
    output logic    o_capture,
    output logic    o_t1_set,
    output logic    o_t1_trigger,
    output logic    o_t1_stop,
    output logic    o_t2_set,
    output logic    o_t2_trigger,
    output logic    o_t2_stop
);

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_WAIT, ST_DONE} state_t;

    state_t state;
    logic   access;
    logic   spi_wr;
    logic   wait_over;

    assign access    = (state == ST_ACCESS);
    assign spi_wr    = (i_sel == SEL_SPI_DATA) && i_bus_we;
    // Only an SPI data write holds the bus for the shifter
    assign wait_over = !spi_wr || i_spi_done;

    // ----------------------------------------
    // Strobes, one cycle each
    // ----------------------------------------
    assign o_spi_start  = access && spi_wr;
    assign o_reg_we     = access && i_bus_we;
    assign o_t1_set     = o_reg_we && (i_sel == SEL_T1_VAL);
    assign o_t1_trigger = o_reg_we && (i_sel == SEL_T1_CTRL) && i_bus_data0;
    assign o_t1_stop    = o_reg_we && (i_sel == SEL_T1_CTRL) && !i_bus_data0;
    assign o_t2_set     = o_reg_we && (i_sel == SEL_T2_VAL);
    assign o_t2_trigger = o_reg_we && (i_sel == SEL_T2_CTRL) && i_bus_data0;
    assign o_t2_stop    = o_reg_we && (i_sel == SEL_T2_CTRL) && !i_bus_data0;

    // Read data is latched on the way into DONE
    assign o_capture    = (state == ST_WAIT) && wait_over;
    assign o_bus_done   = (state == ST_DONE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (i_bus_start)
                        state <= ST_ACCESS;
                ST_ACCESS:
                    state <= ST_WAIT;
                ST_WAIT:
                    if (wait_over)
                        state <= ST_DONE;
                // Start is still high here, so back to idle without sampling it
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* src/io_decoder.sv */
`timescale 1ns/1ps
`include "io_unit_params.svh"

module io_decoder
    import io_map_pkg::*;
(
    input  logic [`IO_ADDR_W-1:0] i_bus_addr,
    output io_sel_t               o_sel
);

    // Exact match against each mapped register
    always_comb
    begin
        case (i_bus_addr)
            `IO_A_SPI_DATA:
                o_sel = SEL_SPI_DATA;
            `IO_A_SPI_CS:
                o_sel = SEL_SPI_CS;
            `IO_A_SPI_NINT:
                o_sel = SEL_SPI_NINT;
            `IO_A_GPIO:
                o_sel = SEL_GPIO;
            `IO_A_T1_VAL:
                o_sel = SEL_T1_VAL;
            `IO_A_T1_CTRL:
                o_sel = SEL_T1_CTRL;
            `IO_A_T2_VAL:
                o_sel = SEL_T2_VAL;
            `IO_A_T2_CTRL:
                o_sel = SEL_T2_CTRL;
            `IO_A_BOOT:
                o_sel = SEL_BOOT;
            // Everything else in the space is a hole
            default:
                o_sel = SEL_NONE;
        endcase
    end

endmodule

/* src/periph_pkg.sv */
package periph_pkg;

    // ----------------------------------------
    // Peripheral data types
    // ----------------------------------------

    // One byte on the SPI wire
    typedef logic [7:0]  io_byte_t;

    // Timer reload and count
    typedef logic [31:0] timer_val_t;

    // General purpose pins
    typedef logic [3:0]  gpo_t;
    typedef logic [3:0]  gpi_t;

endpackage

/* src/io_map_pkg.sv */
package io_map_pkg;

    // ----------------------------------------
    // Access targets on the I/O bus
    // ----------------------------------------

    // One entry per mapped register, plus the unmapped case
    typedef enum logic [3:0]
    {
        SEL_SPI_DATA,
        SEL_SPI_CS,
        SEL_SPI_NINT,
        SEL_GPIO,
        SEL_T1_VAL,
        SEL_T1_CTRL,
        SEL_T2_VAL,
        SEL_T2_CTRL,
        SEL_BOOT,
        // Read as zero, writes dropped
        SEL_NONE
    } io_sel_t;

endpackage

/* src/io_unit_params.svh */
`ifndef IO_UNIT_PARAMS_SVH
`define IO_UNIT_PARAMS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define IO_ADDR_W 27
`define IO_DATA_W 32

// Clocks per half SCLK period on the CH376T port
`define IO_SPI_HALF_BIT 2

// ----------------------------------------
// I/O register addresses
// ----------------------------------------
`define IO_A_SPI_DATA 27'hC0272B
`define IO_A_SPI_CS   27'hC0272C
`define IO_A_SPI_NINT 27'hC0272D
`define IO_A_GPIO     27'hC02737
`define IO_A_T1_VAL   27'hC02739
`define IO_A_T1_CTRL  27'hC0273A
`define IO_A_T2_VAL   27'hC0273B
`define IO_A_T2_CTRL  27'hC0273C
`define IO_A_BOOT     27'hC02741

`endif
